/* source/l1d_arb_pkg.sv */
package l1d_arb_pkg;

  // bank geometry
  localparam int L1D_BANK_ID_W  = 2;
  localparam int L1D_BANK_NUM   = 1 << L1D_BANK_ID_W;
  localparam int L1D_INDEX_W    = 8;   // low bits select the bank
  localparam int L1D_BANK_SET_W = L1D_INDEX_W - L1D_BANK_ID_W;
  localparam int L1D_OFFSET_W   = 6;   // 64 byte line
  localparam int L1D_TAG_W      = 20;

  // address and data widths
  localparam int PADDR_W    = 32;
  localparam int PPN_W      = 20;
  localparam int XLEN       = 64;
  localparam int L1D_LINE_W = 8 << L1D_OFFSET_W;
  localparam int L1D_MASK_W = L1D_LINE_W / 8;
  localparam int ROB_TAG_W  = 6;
  localparam int PREG_W     = 6;

  typedef logic [L1D_BANK_ID_W-1:0]  bank_id_t;
  typedef logic [L1D_INDEX_W-1:0]    set_idx_t;
  typedef logic [L1D_BANK_SET_W-1:0] bank_set_t;
  typedef logic [L1D_OFFSET_W-1:0]   offset_t;
  typedef logic [L1D_TAG_W-1:0]      vtag_t;
  typedef logic [PADDR_W-1:0]        paddr_t;
  typedef logic [PPN_W-1:0]          ppn_t;
  typedef logic [ROB_TAG_W-1:0]      rob_tag_t;
  typedef logic [PREG_W-1:0]         preg_t;
  typedef logic [XLEN-1:0]           xdata_t;
  typedef logic [L1D_LINE_W-1:0]     line_data_t;
  typedef logic [L1D_MASK_W-1:0]     byte_mask_t;

  typedef enum logic [3:0] {
    LB  = 4'd0,
    LH  = 4'd1,
    LW  = 4'd2,
    LD  = 4'd3,
    LBU = 4'd4,
    LHU = 4'd5,
    LWU = 4'd6
  } ld_op_e;

  // value is log2 of the store size in bytes
  typedef enum logic [1:0] {
    SB = 2'd0,
    SH = 2'd1,
    SW = 2'd2,
    SD = 2'd3
  } st_op_e;

endpackage

/* source/rr_arbiter.sv */
`timescale 1ns/10ps

module rr_arbiter #(
  parameter int N_INPUT = 2,
  parameter int IDX_W   = (N_INPUT > 1) ? $clog2(N_INPUT) : 1
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [N_INPUT-1:0] req_i,
  output logic [N_INPUT-1:0] grt_o,
  output logic [IDX_W-1:0]   grt_idx_o
);

  logic [IDX_W-1:0] ptr;      // highest priority input this cycle
  logic [IDX_W-1:0] nxt_ptr;

  // search from the pointer upward, wrapping at N_INPUT
  always_comb begin
    int   pos;
    logic found;
    grt_o     = '0;
    grt_idx_o = '0;
    found     = 1'b0;
    for (int k = 0; k < N_INPUT; k++) begin
      pos = (int'(ptr) + k) % N_INPUT;
      if (!found && req_i[pos]) begin
        found      = 1'b1;
        grt_o[pos] = 1'b1;
        grt_idx_o  = IDX_W'(pos);
      end
    end
  end

  assign nxt_ptr = (int'(grt_idx_o) == N_INPUT - 1) ? '0 : grt_idx_o + 1'b1;

  // pointer moves past the winner, ready or not
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ptr <= '0;
    end else if (|req_i) begin
      ptr <= nxt_ptr;
    end
  end

  a_grt_onehot: assert property (@(posedge clk) disable iff (!rst)
    $onehot0(grt_o));

  a_grt_when_req: assert property (@(posedge clk) disable iff (!rst)
    (|req_i) |-> (|(grt_o & req_i)));

endmodule

/* source/st_mask_gen.sv */
`timescale 1ns/10ps

module st_mask_gen
  import l1d_arb_pkg::*;
(
  input  xdata_t     st_data_i,
  input  st_op_e     st_opcode_i,
  input  offset_t    st_offset_i,
  output line_data_t line_data_o,
  output byte_mask_t byte_mask_o
);

  logic [XLEN/8-1:0] size_mask;   // bytes of the pipe word that are stored
  xdata_t            data_keep;
  logic [8:0]        bit_shift;   // byte offset in bits

  always_comb begin
    unique case (st_opcode_i)
      SB: size_mask = 8'h01;
      SH: size_mask = 8'h03;
      SW: size_mask = 8'h0f;
      SD: size_mask = 8'hff;
    endcase
  end

  // clear bytes above the store size
  always_comb begin
    for (int b = 0; b < XLEN/8; b++) begin
      data_keep[b*8 +: 8] = st_data_i[b*8 +: 8] & {8{size_mask[b]}};
    end
  end

  assign bit_shift   = {st_offset_i, 3'b000};
  assign line_data_o = line_data_t'(data_keep) << bit_shift;
  assign byte_mask_o = byte_mask_t'(size_mask) << st_offset_i;

endmodule

/* source/ld_bank_arb.sv */
`timescale 1ns/10ps

module ld_bank_arb
  import l1d_arb_pkg::*;
#(
  parameter int BANK      = 0,
  parameter int N_LD_PORT = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic     [N_LD_PORT-1:0] ld_vld_i,
  input  rob_tag_t [N_LD_PORT-1:0] ld_rob_tag_i,
  input  preg_t    [N_LD_PORT-1:0] ld_prd_i,
  input  ld_op_e   [N_LD_PORT-1:0] ld_opcode_i,
  input  set_idx_t [N_LD_PORT-1:0] ld_idx_i,
  input  offset_t  [N_LD_PORT-1:0] ld_offset_i,
  input  vtag_t    [N_LD_PORT-1:0] ld_vtag_i,
  output logic                     bank_vld_o,
  output rob_tag_t                 bank_rob_tag_o,
  output preg_t                    bank_prd_o,
  output ld_op_e                   bank_opcode_o,
  output bank_set_t                bank_idx_o,
  output offset_t                  bank_offset_o,
  output vtag_t                    bank_vtag_o,
  output logic     [N_LD_PORT-1:0] grt_o
);

  localparam int       LD_IDX_W = (N_LD_PORT > 1) ? $clog2(N_LD_PORT) : 1;
  localparam bank_id_t BANK_ID  = bank_id_t'(BANK);

  logic [N_LD_PORT-1:0] match;    // ports whose set index lands here
  logic [LD_IDX_W-1:0]  grt_idx;

  always_comb begin
    for (int p = 0; p < N_LD_PORT; p++) begin
      match[p] = ld_vld_i[p] && (ld_idx_i[p][L1D_BANK_ID_W-1:0] == BANK_ID);
    end
  end

  rr_arbiter #(
    .N_INPUT   (N_LD_PORT)
  ) u_rr_arbiter (
    .clk       (clk),
    .rst       (rst),
    .req_i     (match),
    .grt_o     (grt_o),
    .grt_idx_o (grt_idx)
  );

  assign bank_vld_o     = |grt_o;
  assign bank_rob_tag_o = ld_rob_tag_i[grt_idx];
  assign bank_prd_o     = ld_prd_i[grt_idx];
  assign bank_opcode_o  = ld_opcode_i[grt_idx];
  assign bank_idx_o     = ld_idx_i[grt_idx][L1D_INDEX_W-1 -: L1D_BANK_SET_W]; // drop bank bits
  assign bank_offset_o  = ld_offset_i[grt_idx];
  assign bank_vtag_o    = ld_vtag_i[grt_idx];

endmodule

/* source/st_bank_arb.sv */
`timescale 1ns/10ps

module st_bank_arb
  import l1d_arb_pkg::*;
#(
  parameter int BANK      = 0,
  parameter int N_ST_PORT = 1
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic     [N_ST_PORT-1:0] st_vld_i,
  input  rob_tag_t [N_ST_PORT-1:0] st_rob_tag_i,
  input  preg_t    [N_ST_PORT-1:0] st_prd_i,
  input  st_op_e   [N_ST_PORT-1:0] st_opcode_i,
  input  paddr_t   [N_ST_PORT-1:0] st_paddr_i,
  input  xdata_t   [N_ST_PORT-1:0] st_data_i,
  output logic                     bank_vld_o,
  output rob_tag_t                 bank_rob_tag_o,
  output preg_t                    bank_prd_o,
  output st_op_e                   bank_opcode_o,
  output paddr_t                   bank_paddr_o,
  output line_data_t               bank_data_o,
  output byte_mask_t               bank_mask_o,
  output logic                     bank_io_region_o,
  output logic     [N_ST_PORT-1:0] grt_o
);

  localparam int       ST_IDX_W = (N_ST_PORT > 1) ? $clog2(N_ST_PORT) : 1;
  localparam bank_id_t BANK_ID  = bank_id_t'(BANK);

  logic [N_ST_PORT-1:0] match;
  logic [ST_IDX_W-1:0]  grt_idx;
  logic [2:0]           size_low;  // low offset bits that must be zero

  // bank comes from the paddr bits right above the line offset
  always_comb begin
    for (int p = 0; p < N_ST_PORT; p++) begin
      match[p] = st_vld_i[p] && (st_paddr_i[p][L1D_OFFSET_W +: L1D_BANK_ID_W] == BANK_ID);
    end
  end

  if (N_ST_PORT > 1) begin : g_rr
    rr_arbiter #(
      .N_INPUT   (N_ST_PORT)
    ) u_rr_arbiter (
      .clk       (clk),
      .rst       (rst),
      .req_i     (match),
      .grt_o     (grt_o),
      .grt_idx_o (grt_idx)
    );
  end else begin : g_single
    assign grt_o   = match;   // nothing to arbitrate
    assign grt_idx = '0;
  end

  assign bank_vld_o       = |grt_o;
  assign bank_rob_tag_o   = st_rob_tag_i[grt_idx];
  assign bank_prd_o       = st_prd_i[grt_idx];
  assign bank_opcode_o    = st_opcode_i[grt_idx];
  assign bank_paddr_o     = st_paddr_i[grt_idx];
  assign bank_io_region_o = 1'b0;

  st_mask_gen u_st_mask_gen (
    .st_data_i   (st_data_i[grt_idx]),
    .st_opcode_i (st_opcode_i[grt_idx]),
    .st_offset_i (st_paddr_i[grt_idx][L1D_OFFSET_W-1:0]),
    .line_data_o (bank_data_o),
    .byte_mask_o (bank_mask_o)
  );

  assign size_low = 3'((4'd1 << bank_opcode_o) - 4'd1);

  // a store sent to the bank never straddles its natural alignment
  a_st_aligned: assert property (@(posedge clk) disable iff (!rst)
    bank_vld_o |-> ((bank_paddr_o[2:0] & size_low) == 3'b000));

endmodule

/* source/port_resp_merge.sv */
`timescale 1ns/10ps

module port_resp_merge
  import l1d_arb_pkg::*;
#(
  parameter int N_LD_PORT = 2,
  parameter int N_ST_PORT = 1
) (
  input  logic     [L1D_BANK_NUM-1:0][N_LD_PORT-1:0] ld_grt_i,
  input  logic     [L1D_BANK_NUM-1:0]                ld_bank_rdy_i,
  input  logic     [L1D_BANK_NUM-1:0][N_ST_PORT-1:0] st_grt_i,
  input  logic     [L1D_BANK_NUM-1:0]                st_bank_rdy_i,
  output logic     [N_LD_PORT-1:0]                   ld_rdy_o,
  output bank_id_t [N_LD_PORT-1:0]                   ld_hit_bank_id_o,
  output logic     [N_ST_PORT-1:0]                   st_rdy_o
);

  // a port sees the ready of whichever bank granted it
  always_comb begin
    ld_rdy_o         = '0;
    ld_hit_bank_id_o = '0;
    for (int b = 0; b < L1D_BANK_NUM; b++) begin
      for (int p = 0; p < N_LD_PORT; p++) begin
        if (ld_grt_i[b][p]) begin
          ld_rdy_o[p]         = ld_bank_rdy_i[b];
          ld_hit_bank_id_o[p] = bank_id_t'(b);
        end
      end
    end
  end

  always_comb begin
    st_rdy_o = '0;
    for (int b = 0; b < L1D_BANK_NUM; b++) begin
      for (int p = 0; p < N_ST_PORT; p++) begin
        if (st_grt_i[b][p]) begin
          st_rdy_o[p] = st_bank_rdy_i[b];
        end
      end
    end
  end

endmodule

/* source/dtlb_resp_fwd.sv */
`timescale 1ns/10ps

module dtlb_resp_fwd
  import l1d_arb_pkg::*;
#(
  parameter int N_LD_PORT = 2
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic     [N_LD_PORT-1:0]    ld_vld_i,
  input  logic     [N_LD_PORT-1:0]    ld_rdy_i,
  input  set_idx_t [N_LD_PORT-1:0]    ld_idx_i,
  input  logic     [N_LD_PORT-1:0]    dtlb_vld_i,
  input  logic     [N_LD_PORT-1:0]    dtlb_excp_i,
  input  logic     [N_LD_PORT-1:0]    dtlb_hit_i,
  input  ppn_t     [N_LD_PORT-1:0]    dtlb_ppn_i,
  output logic     [L1D_BANK_NUM-1:0] bank_dtlb_vld_o,
  output logic     [L1D_BANK_NUM-1:0] bank_dtlb_excp_o,
  output logic     [L1D_BANK_NUM-1:0] bank_dtlb_hit_o,
  output ppn_t     [L1D_BANK_NUM-1:0] bank_dtlb_ppn_o
);

  logic     [N_LD_PORT-1:0] acc_q;       // port handed a load over last cycle
  bank_id_t [N_LD_PORT-1:0] acc_bank_q;  // and the bank that took it

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      acc_q      <= '0;
      acc_bank_q <= '0;
    end else begin
      acc_q <= ld_vld_i & ld_rdy_i;
      for (int p = 0; p < N_LD_PORT; p++) begin
        if (ld_vld_i[p] && ld_rdy_i[p]) begin
          acc_bank_q[p] <= ld_idx_i[p][L1D_BANK_ID_W-1:0];
        end
      end
    end
  end

  // live dtlb inputs of the port go to the bank it loaded from
  always_comb begin
    bank_dtlb_vld_o  = '0;
    bank_dtlb_excp_o = '0;
    bank_dtlb_hit_o  = '0;
    bank_dtlb_ppn_o  = '0;
    for (int b = 0; b < L1D_BANK_NUM; b++) begin
      for (int p = 0; p < N_LD_PORT; p++) begin
        if (acc_q[p] && (acc_bank_q[p] == bank_id_t'(b))) begin
          bank_dtlb_vld_o[b]  = dtlb_vld_i[p];
          bank_dtlb_excp_o[b] = dtlb_excp_i[p];
          bank_dtlb_hit_o[b]  = dtlb_hit_i[p];
          bank_dtlb_ppn_o[b]  = dtlb_ppn_i[p];
        end
      end
    end
  end

endmodule

/* source/l1d_bank_input_arb.sv */
`timescale 1ns/10ps

module l1d_bank_input_arb
  import l1d_arb_pkg::*;
#(
  parameter int N_LD_PORT = 2,
  parameter int N_ST_PORT = 1
) (
  input  logic                          clk,
  input  logic                          rst,
  // load pipes
  input  logic       [N_LD_PORT-1:0]    ld_vld_i,
  input  rob_tag_t   [N_LD_PORT-1:0]    ld_rob_tag_i,
  input  preg_t      [N_LD_PORT-1:0]    ld_prd_i,
  input  ld_op_e     [N_LD_PORT-1:0]    ld_opcode_i,
  input  set_idx_t   [N_LD_PORT-1:0]    ld_idx_i,
  input  offset_t    [N_LD_PORT-1:0]    ld_offset_i,
  input  vtag_t      [N_LD_PORT-1:0]    ld_vtag_i,
  output logic       [N_LD_PORT-1:0]    ld_rdy_o,
  output bank_id_t   [N_LD_PORT-1:0]    ld_hit_bank_id_o,
  input  logic       [N_LD_PORT-1:0]    dtlb_vld_i,   // one cycle behind the load
  input  logic       [N_LD_PORT-1:0]    dtlb_excp_i,
  input  logic       [N_LD_PORT-1:0]    dtlb_hit_i,
  input  ppn_t       [N_LD_PORT-1:0]    dtlb_ppn_i,
  // store pipes
  input  logic       [N_ST_PORT-1:0]    st_vld_i,
  input  rob_tag_t   [N_ST_PORT-1:0]    st_rob_tag_i,
  input  preg_t      [N_ST_PORT-1:0]    st_prd_i,
  input  st_op_e     [N_ST_PORT-1:0]    st_opcode_i,
  input  paddr_t     [N_ST_PORT-1:0]    st_paddr_i,
  input  xdata_t     [N_ST_PORT-1:0]    st_data_i,
  output logic       [N_ST_PORT-1:0]    st_rdy_o,
  // cache banks, load side
  output logic       [L1D_BANK_NUM-1:0] bank_ld_vld_o,
  output rob_tag_t   [L1D_BANK_NUM-1:0] bank_ld_rob_tag_o,
  output preg_t      [L1D_BANK_NUM-1:0] bank_ld_prd_o,
  output ld_op_e     [L1D_BANK_NUM-1:0] bank_ld_opcode_o,
  output bank_set_t  [L1D_BANK_NUM-1:0] bank_ld_idx_o,
  output offset_t    [L1D_BANK_NUM-1:0] bank_ld_offset_o,
  output vtag_t      [L1D_BANK_NUM-1:0] bank_ld_vtag_o,
  input  logic       [L1D_BANK_NUM-1:0] bank_ld_rdy_i,
  output logic       [L1D_BANK_NUM-1:0] bank_dtlb_vld_o,
  output logic       [L1D_BANK_NUM-1:0] bank_dtlb_excp_o,
  output logic       [L1D_BANK_NUM-1:0] bank_dtlb_hit_o,
  output ppn_t       [L1D_BANK_NUM-1:0] bank_dtlb_ppn_o,
  // cache banks, store side
  output logic       [L1D_BANK_NUM-1:0] bank_st_vld_o,
  output logic       [L1D_BANK_NUM-1:0] bank_st_io_region_o,
  output rob_tag_t   [L1D_BANK_NUM-1:0] bank_st_rob_tag_o,
  output preg_t      [L1D_BANK_NUM-1:0] bank_st_prd_o,
  output st_op_e     [L1D_BANK_NUM-1:0] bank_st_opcode_o,
  output paddr_t     [L1D_BANK_NUM-1:0] bank_st_paddr_o,
  output line_data_t [L1D_BANK_NUM-1:0] bank_st_data_o,
  output byte_mask_t [L1D_BANK_NUM-1:0] bank_st_mask_o,
  input  logic       [L1D_BANK_NUM-1:0] bank_st_rdy_i
);

  logic [L1D_BANK_NUM-1:0][N_LD_PORT-1:0] ld_grt;  // one-hot per bank
  logic [L1D_BANK_NUM-1:0][N_ST_PORT-1:0] st_grt;

  for (genvar b = 0; b < L1D_BANK_NUM; b++) begin : g_bank
    ld_bank_arb #(
      .BANK           (b),
      .N_LD_PORT      (N_LD_PORT)
    ) u_ld_bank_arb (
      .clk            (clk),
      .rst            (rst),
      .ld_vld_i       (ld_vld_i),
      .ld_rob_tag_i   (ld_rob_tag_i),
      .ld_prd_i       (ld_prd_i),
      .ld_opcode_i    (ld_opcode_i),
      .ld_idx_i       (ld_idx_i),
      .ld_offset_i    (ld_offset_i),
      .ld_vtag_i      (ld_vtag_i),
      .bank_vld_o     (bank_ld_vld_o[b]),
      .bank_rob_tag_o (bank_ld_rob_tag_o[b]),
      .bank_prd_o     (bank_ld_prd_o[b]),
      .bank_opcode_o  (bank_ld_opcode_o[b]),
      .bank_idx_o     (bank_ld_idx_o[b]),
      .bank_offset_o  (bank_ld_offset_o[b]),
      .bank_vtag_o    (bank_ld_vtag_o[b]),
      .grt_o          (ld_grt[b])
    );

    st_bank_arb #(
      .BANK             (b),
      .N_ST_PORT        (N_ST_PORT)
    ) u_st_bank_arb (
      .clk              (clk),
      .rst              (rst),
      .st_vld_i         (st_vld_i),
      .st_rob_tag_i     (st_rob_tag_i),
      .st_prd_i         (st_prd_i),
      .st_opcode_i      (st_opcode_i),
      .st_paddr_i       (st_paddr_i),
      .st_data_i        (st_data_i),
      .bank_vld_o       (bank_st_vld_o[b]),
      .bank_rob_tag_o   (bank_st_rob_tag_o[b]),
      .bank_prd_o       (bank_st_prd_o[b]),
      .bank_opcode_o    (bank_st_opcode_o[b]),
      .bank_paddr_o     (bank_st_paddr_o[b]),
      .bank_data_o      (bank_st_data_o[b]),
      .bank_mask_o      (bank_st_mask_o[b]),
      .bank_io_region_o (bank_st_io_region_o[b]),
      .grt_o            (st_grt[b])
    );
  end

  port_resp_merge #(
    .N_LD_PORT        (N_LD_PORT),
    .N_ST_PORT        (N_ST_PORT)
  ) u_port_resp_merge (
    .ld_grt_i         (ld_grt),
    .ld_bank_rdy_i    (bank_ld_rdy_i),
    .st_grt_i         (st_grt),
    .st_bank_rdy_i    (bank_st_rdy_i),
    .ld_rdy_o         (ld_rdy_o),
    .ld_hit_bank_id_o (ld_hit_bank_id_o),
    .st_rdy_o         (st_rdy_o)
  );

  dtlb_resp_fwd #(
    .N_LD_PORT        (N_LD_PORT)
  ) u_dtlb_resp_fwd (
    .clk              (clk),
    .rst              (rst),
    .ld_vld_i         (ld_vld_i),
    .ld_rdy_i         (ld_rdy_o),
    .ld_idx_i         (ld_idx_i),
    .dtlb_vld_i       (dtlb_vld_i),
    .dtlb_excp_i      (dtlb_excp_i),
    .dtlb_hit_i       (dtlb_hit_i),
    .dtlb_ppn_i       (dtlb_ppn_i),
    .bank_dtlb_vld_o  (bank_dtlb_vld_o),
    .bank_dtlb_excp_o (bank_dtlb_excp_o),
    .bank_dtlb_hit_o  (bank_dtlb_hit_o),
    .bank_dtlb_ppn_o  (bank_dtlb_ppn_o)
  );

  // a port is never granted by two banks at once
  for (genvar p = 0; p < N_LD_PORT; p++) begin : g_ld_chk
    logic [L1D_BANK_NUM-1:0] grt_banks;
    for (genvar b = 0; b < L1D_BANK_NUM; b++) begin : g_col
      assign grt_banks[b] = ld_grt[b][p];
    end
    a_ld_one_bank: assert property (@(posedge clk) disable iff (!rst) $onehot0(grt_banks));
  end

  for (genvar p = 0; p < N_ST_PORT; p++) begin : g_st_chk
    logic [L1D_BANK_NUM-1:0] grt_banks;
    for (genvar b = 0; b < L1D_BANK_NUM; b++) begin : g_col
      assign grt_banks[b] = st_grt[b][p];
    end
    a_st_one_bank: assert property (@(posedge clk) disable iff (!rst) $onehot0(grt_banks));
  end

endmodule

/* tb/tb_l1d_bank_input_arb.sv */
`timescale 1ns/10ps

module tb_l1d_bank_input_arb
  import l1d_arb_pkg::*;
();

  localparam int N_LD       = 2;
  localparam int N_ST       = 2;
  localparam int MAX_CYCLES = 100;  // the tests take about 50 cycles

  logic clk = 1'b0;
  logic rst;
  int   cycle_cnt = 0;
  string test_name = "reset";

  logic       [N_LD-1:0]         ld_vld;
  rob_tag_t   [N_LD-1:0]         ld_rob_tag;
  preg_t      [N_LD-1:0]         ld_prd;
  ld_op_e     [N_LD-1:0]         ld_opcode;
  set_idx_t   [N_LD-1:0]         ld_idx;
  offset_t    [N_LD-1:0]         ld_offset;
  vtag_t      [N_LD-1:0]         ld_vtag;
  logic       [N_LD-1:0]         ld_rdy;
  bank_id_t   [N_LD-1:0]         ld_hit_bank_id;
  logic       [N_LD-1:0]         dtlb_vld;
  logic       [N_LD-1:0]         dtlb_excp;
  logic       [N_LD-1:0]         dtlb_hit;
  ppn_t       [N_LD-1:0]         dtlb_ppn;
  logic       [N_ST-1:0]         st_vld;
  rob_tag_t   [N_ST-1:0]         st_rob_tag;
  preg_t      [N_ST-1:0]         st_prd;
  st_op_e     [N_ST-1:0]         st_opcode;
  paddr_t     [N_ST-1:0]         st_paddr;
  xdata_t     [N_ST-1:0]         st_data;
  logic       [N_ST-1:0]         st_rdy;
  logic       [L1D_BANK_NUM-1:0] bank_ld_vld;
  rob_tag_t   [L1D_BANK_NUM-1:0] bank_ld_rob_tag;
  preg_t      [L1D_BANK_NUM-1:0] bank_ld_prd;
  ld_op_e     [L1D_BANK_NUM-1:0] bank_ld_opcode;
  bank_set_t  [L1D_BANK_NUM-1:0] bank_ld_idx;
  offset_t    [L1D_BANK_NUM-1:0] bank_ld_offset;
  vtag_t      [L1D_BANK_NUM-1:0] bank_ld_vtag;
  logic       [L1D_BANK_NUM-1:0] bank_ld_rdy;
  logic       [L1D_BANK_NUM-1:0] bank_dtlb_vld;
  logic       [L1D_BANK_NUM-1:0] bank_dtlb_excp;
  logic       [L1D_BANK_NUM-1:0] bank_dtlb_hit;
  ppn_t       [L1D_BANK_NUM-1:0] bank_dtlb_ppn;
  logic       [L1D_BANK_NUM-1:0] bank_st_vld;
  logic       [L1D_BANK_NUM-1:0] bank_st_io_region;
  rob_tag_t   [L1D_BANK_NUM-1:0] bank_st_rob_tag;
  preg_t      [L1D_BANK_NUM-1:0] bank_st_prd;
  st_op_e     [L1D_BANK_NUM-1:0] bank_st_opcode;
  paddr_t     [L1D_BANK_NUM-1:0] bank_st_paddr;
  line_data_t [L1D_BANK_NUM-1:0] bank_st_data;
  byte_mask_t [L1D_BANK_NUM-1:0] bank_st_mask;
  logic       [L1D_BANK_NUM-1:0] bank_st_rdy;

  l1d_bank_input_arb #(
    .N_LD_PORT (N_LD),
    .N_ST_PORT (N_ST)
  ) dut0 (
    .clk (clk), .rst (rst),
    .ld_vld_i (ld_vld), .ld_rob_tag_i (ld_rob_tag), .ld_prd_i (ld_prd),
    .ld_opcode_i (ld_opcode), .ld_idx_i (ld_idx), .ld_offset_i (ld_offset),
    .ld_vtag_i (ld_vtag), .ld_rdy_o (ld_rdy), .ld_hit_bank_id_o (ld_hit_bank_id),
    .dtlb_vld_i (dtlb_vld), .dtlb_excp_i (dtlb_excp), .dtlb_hit_i (dtlb_hit),
    .dtlb_ppn_i (dtlb_ppn),
    .st_vld_i (st_vld), .st_rob_tag_i (st_rob_tag), .st_prd_i (st_prd),
    .st_opcode_i (st_opcode), .st_paddr_i (st_paddr), .st_data_i (st_data),
    .st_rdy_o (st_rdy),
    .bank_ld_vld_o (bank_ld_vld), .bank_ld_rob_tag_o (bank_ld_rob_tag),
    .bank_ld_prd_o (bank_ld_prd), .bank_ld_opcode_o (bank_ld_opcode),
    .bank_ld_idx_o (bank_ld_idx), .bank_ld_offset_o (bank_ld_offset),
    .bank_ld_vtag_o (bank_ld_vtag), .bank_ld_rdy_i (bank_ld_rdy),
    .bank_dtlb_vld_o (bank_dtlb_vld), .bank_dtlb_excp_o (bank_dtlb_excp),
    .bank_dtlb_hit_o (bank_dtlb_hit), .bank_dtlb_ppn_o (bank_dtlb_ppn),
    .bank_st_vld_o (bank_st_vld), .bank_st_io_region_o (bank_st_io_region),
    .bank_st_rob_tag_o (bank_st_rob_tag), .bank_st_prd_o (bank_st_prd),
    .bank_st_opcode_o (bank_st_opcode), .bank_st_paddr_o (bank_st_paddr),
    .bank_st_data_o (bank_st_data), .bank_st_mask_o (bank_st_mask),
    .bank_st_rdy_i (bank_st_rdy)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run went past %0d clock cycles", MAX_CYCLES);
      fail_stop();
    end
  end

  task automatic fail_stop();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0b, actual %0b", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_bank_id(input string what, input bank_id_t exp, input bank_id_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_set(input string what, input bank_set_t exp, input bank_set_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_vtag(input string what, input vtag_t exp, input vtag_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_rob_tag(input string what, input rob_tag_t exp, input rob_tag_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_preg(input string what, input preg_t exp, input preg_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_ld_op(input string what, input ld_op_e exp, input ld_op_e act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_st_op(input string what, input st_op_e exp, input st_op_e act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_offset(input string what, input offset_t exp, input offset_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_paddr(input string what, input paddr_t exp, input paddr_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_line(input string what, input line_data_t exp, input line_data_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_mask(input string what, input byte_mask_t exp, input byte_mask_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_ppn(input string what, input ppn_t exp, input ppn_t act);
    if (exp !== act) begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      fail_stop();
    end
  endtask

  // low 2^op bytes of the store word land at byte off of the line
  function automatic line_data_t place_data(input xdata_t d, input st_op_e op,
                                            input offset_t off);
    line_data_t l;
    int         n;
    l = '0;
    n = 1 << int'(op);
    for (int i = 0; i < n; i++) begin
      l[(int'(off) + i) * 8 +: 8] = d[i * 8 +: 8];
    end
    return l;
  endfunction

  function automatic byte_mask_t mask_for(input st_op_e op, input offset_t off);
    byte_mask_t m;
    m = '0;
    for (int i = 0; i < (1 << int'(op)); i++) begin
      m[int'(off) + i] = 1'b1;
    end
    return m;
  endfunction

  task automatic idle_inputs();
    ld_vld      = '0;
    ld_rob_tag  = '0;
    ld_prd      = '0;
    ld_opcode   = {N_LD{LB}};
    ld_idx      = '0;
    ld_offset   = '0;
    ld_vtag     = '0;
    dtlb_vld    = '0;
    dtlb_excp   = '0;
    dtlb_hit    = '0;
    dtlb_ppn    = '0;
    st_vld      = '0;
    st_rob_tag  = '0;
    st_prd      = '0;
    st_opcode   = {N_ST{SB}};
    st_paddr    = '0;
    st_data     = '0;
    bank_ld_rdy = '0;
    bank_st_rdy = '0;
  endtask

  task automatic drive_load(input int p, input set_idx_t idx);
    ld_vld[p]     = 1'b1;
    ld_idx[p]     = idx;
    ld_offset[p]  = offset_t'($urandom);
    ld_vtag[p]    = vtag_t'($urandom);
    ld_rob_tag[p] = rob_tag_t'($urandom);
    ld_prd[p]     = preg_t'($urandom);
    ld_opcode[p]  = ld_op_e'($urandom_range(0, 6));
  endtask

  task automatic drive_store(input int p, input paddr_t addr, input st_op_e op);
    st_vld[p]     = 1'b1;
    st_paddr[p]   = addr;
    st_opcode[p]  = op;
    st_data[p]    = {$urandom, $urandom};
    st_rob_tag[p] = rob_tag_t'($urandom);
    st_prd[p]     = preg_t'($urandom);
  endtask

  // both ports on one bank, pointer starts at port 0 after reset
  task automatic run_ld_conflict();
    bank_id_t b;
    int       win;
    test_name = "ld_conflict";
    b = bank_id_t'($urandom);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      idle_inputs();
      bank_ld_rdy = '1;
      drive_load(0, {6'($urandom), b});
      drive_load(1, {6'($urandom), b});
      ld_vtag[1] = ~ld_vtag[0];  // tells the winner apart
      #10;
      win = i % 2;
      check_bit("winner rdy", 1'b1, ld_rdy[win]);
      check_bit("loser rdy", 1'b0, ld_rdy[1-win]);
      check_vtag("bank vtag", ld_vtag[win], bank_ld_vtag[b]);
      check_bank_id("hit bank id", b, ld_hit_bank_id[win]);
    end
  endtask

  task automatic run_st_conflict();
    bank_id_t b;
    int       win;
    test_name = "st_conflict";
    b = bank_id_t'($urandom);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      idle_inputs();
      bank_st_rdy = '1;
      drive_store(0, {24'($urandom), b, 3'($urandom), 3'b000}, SD);
      drive_store(1, {24'($urandom), b, 3'($urandom), 3'b000}, SD);
      #10;
      win = i % 2;
      check_bit("winner rdy", 1'b1, st_rdy[win]);
      check_bit("loser rdy", 1'b0, st_rdy[1-win]);
      check_line("bank data", place_data(st_data[win], SD, st_paddr[win][5:0]),
                 bank_st_data[b]);
    end
  endtask

  task automatic run_single_ld();
    set_idx_t idx;
    bank_id_t bnk;
    int       p;
    test_name = "single_ld";
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      idle_inputs();
      p = i % 2;
      idx = set_idx_t'($urandom);
      bnk = idx[1:0];
      bank_ld_rdy = 4'($urandom);
      drive_load(p, idx);
      #10;
      for (int b = 0; b < L1D_BANK_NUM; b++) begin
        check_bit("bank vld", b == int'(bnk), bank_ld_vld[b]);
      end
      check_set("bank set idx", idx[7:2], bank_ld_idx[bnk]);
      check_vtag("bank vtag", ld_vtag[p], bank_ld_vtag[bnk]);
      check_rob_tag("bank rob tag", ld_rob_tag[p], bank_ld_rob_tag[bnk]);
      check_preg("bank prd", ld_prd[p], bank_ld_prd[bnk]);
      check_ld_op("bank opcode", ld_opcode[p], bank_ld_opcode[bnk]);
      check_offset("bank offset", ld_offset[p], bank_ld_offset[bnk]);
      check_bit("port rdy", bank_ld_rdy[bnk], ld_rdy[p]);
      check_bit("idle port rdy", 1'b0, ld_rdy[1-p]);
      check_bank_id("hit bank id", bnk, ld_hit_bank_id[p]);
    end
  endtask

  task automatic run_no_conflict();
    bank_id_t b0;
    bank_id_t b1;
    test_name = "no_conflict";
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      idle_inputs();
      b0 = bank_id_t'($urandom);
      b1 = b0 ^ bank_id_t'($urandom_range(1, 3));  // always a different bank
      bank_ld_rdy = '1;
      drive_load(0, {6'($urandom), b0});
      drive_load(1, {6'($urandom), b1});
      #10;
      check_bit("port0 rdy", 1'b1, ld_rdy[0]);
      check_bit("port1 rdy", 1'b1, ld_rdy[1]);
      check_vtag("bank b0 vtag", ld_vtag[0], bank_ld_vtag[b0]);
      check_vtag("bank b1 vtag", ld_vtag[1], bank_ld_vtag[b1]);
      check_bank_id("port0 hit bank", b0, ld_hit_bank_id[0]);
      check_bank_id("port1 hit bank", b1, ld_hit_bank_id[1]);
    end
  endtask

  task automatic run_backpressure();
    bank_id_t b;
    test_name = "backpressure";
    @(negedge clk);
    idle_inputs();
    b = bank_id_t'($urandom);
    bank_ld_rdy = '1;
    bank_ld_rdy[b] = 1'b0;
    drive_load(0, {6'($urandom), b});
    #10;
    check_bit("bank vld", 1'b1, bank_ld_vld[b]);
    check_bit("port rdy", 1'b0, ld_rdy[0]);
    @(negedge clk);
    idle_inputs();
    dtlb_vld = '1;
    dtlb_excp = '1;
    dtlb_hit = '1;
    dtlb_ppn = {ppn_t'($urandom), ppn_t'($urandom)};
    #10;
    for (int bb = 0; bb < L1D_BANK_NUM; bb++) begin
      check_bit("dtlb vld", 1'b0, bank_dtlb_vld[bb]);
      check_bit("dtlb excp", 1'b0, bank_dtlb_excp[bb]);
      check_bit("dtlb hit", 1'b0, bank_dtlb_hit[bb]);
      check_ppn("dtlb ppn", '0, bank_dtlb_ppn[bb]);
    end
  endtask

  task automatic run_dtlb_fwd();
    bank_id_t b;
    int       p;
    logic     own;
    test_name = "dtlb_fwd";
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      idle_inputs();
      p = i % 2;
      b = bank_id_t'($urandom);
      bank_ld_rdy = '1;
      drive_load(p, {6'($urandom), b});
      #10;
      check_bit("handshake rdy", 1'b1, ld_rdy[p]);
      @(negedge clk);
      idle_inputs();
      dtlb_vld = 2'($urandom);
      dtlb_vld[p] = 1'b1;
      dtlb_excp = 2'($urandom);
      dtlb_hit = 2'($urandom);
      dtlb_ppn = {ppn_t'($urandom), ppn_t'($urandom)};
      #10;
      for (int bb = 0; bb < L1D_BANK_NUM; bb++) begin
        own = (bb == int'(b));
        check_bit("dtlb vld", own & dtlb_vld[p], bank_dtlb_vld[bb]);
        check_bit("dtlb excp", own & dtlb_excp[p], bank_dtlb_excp[bb]);
        check_bit("dtlb hit", own & dtlb_hit[p], bank_dtlb_hit[bb]);
        check_ppn("dtlb ppn", own ? dtlb_ppn[p] : '0, bank_dtlb_ppn[bb]);
      end
    end
  endtask

  task automatic run_store_ops();
    st_op_e   op;
    paddr_t   addr;
    bank_id_t bnk;
    int       p;
    test_name = "store_ops";
    for (int k = 0; k < 4; k++) begin
      op = st_op_e'(k);
      for (int i = 0; i < 3; i++) begin
        @(negedge clk);
        idle_inputs();
        p = i % 2;
        addr = paddr_t'($urandom) & ~paddr_t'((1 << k) - 1);  // size aligned
        bnk = addr[7:6];
        bank_st_rdy = 4'($urandom);
        drive_store(p, addr, op);
        #10;
        for (int b = 0; b < L1D_BANK_NUM; b++) begin
          check_bit("bank vld", b == int'(bnk), bank_st_vld[b]);
          check_bit("io region", 1'b0, bank_st_io_region[b]);
        end
        check_line("line data", place_data(st_data[p], op, addr[5:0]), bank_st_data[bnk]);
        check_mask("byte mask", mask_for(op, addr[5:0]), bank_st_mask[bnk]);
        check_rob_tag("bank rob tag", st_rob_tag[p], bank_st_rob_tag[bnk]);
        check_preg("bank prd", st_prd[p], bank_st_prd[bnk]);
        check_st_op("bank opcode", op, bank_st_opcode[bnk]);
        check_paddr("bank paddr", addr, bank_st_paddr[bnk]);
        check_bit("port rdy", bank_st_rdy[bnk], st_rdy[p]);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h80cde345));
    rst = 1'b0;
    idle_inputs();
    repeat (5) @(negedge clk);
    rst = 1'b1;
    run_ld_conflict();   // must run first, it relies on the reset pointers
    run_st_conflict();
    run_single_ld();
    run_no_conflict();
    run_backpressure();
    run_dtlb_fwd();
    run_store_ops();
    @(negedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* l1d_bank_input_arb.f */
source/l1d_arb_pkg.sv
source/rr_arbiter.sv
source/st_mask_gen.sv
source/ld_bank_arb.sv
source/st_bank_arb.sv
source/port_resp_merge.sv
source/dtlb_resp_fwd.sv
source/l1d_bank_input_arb.sv
tb/tb_l1d_bank_input_arb.sv
